//--- run_sim.sh
#!/usr/bin/env bash
# builds the control unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rv_control.f --top-module tb_control_unit -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

//--- rv_control.f
src/rv_ctrl_pkg.sv
src/instr_decoder.sv
src/alu_op_decoder.sv
src/branch_resolver.sv
src/forward_unit.sv
src/hazard_unit.sv
src/control_unit.sv
tb/tb_control_unit.sv

//--- src/alu_op_decoder.sv
module alu_op_decoder (
    input  logic                  i_is_arith,
    input  logic                  i_is_imm,
    input  logic [2:0]            i_funct3,
    input  logic [6:0]            i_funct7,
    input  rv_ctrl_pkg::alu_op_e  i_fixed_op,
    output rv_ctrl_pkg::alu_op_e  o_aluc
);

    rv_ctrl_pkg::alu_op_e base_op;

    // funct3 table shared by register and immediate forms
    always_comb
    begin
        case (i_funct3)
            3'b001:  base_op = rv_ctrl_pkg::ALU_SLL;
            3'b100:  base_op = rv_ctrl_pkg::ALU_XOR;
            3'b101:  base_op = (i_funct7 == rv_ctrl_pkg::FUNCT7_ALT) ?
                               rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            3'b110:  base_op = rv_ctrl_pkg::ALU_OR;
            3'b111:  base_op = rv_ctrl_pkg::ALU_AND;
            default: base_op = rv_ctrl_pkg::ALU_ADD;    // add and slt variants
        endcase
    end

    always_comb
    begin
        if (!i_is_arith)
            o_aluc = i_fixed_op;                        // loads, stores, lui, auipc
        else if (i_is_imm || i_funct7 == rv_ctrl_pkg::FUNCT7_BASE)
            o_aluc = base_op;
        else if (i_funct7 == rv_ctrl_pkg::FUNCT7_ALT && i_funct3 == 3'b000)
            o_aluc = rv_ctrl_pkg::ALU_SUB;              // sub exists for R-type only
        else if (i_funct7 == rv_ctrl_pkg::FUNCT7_ALT && i_funct3 == 3'b101)
            o_aluc = rv_ctrl_pkg::ALU_SRA;
        else
            o_aluc = rv_ctrl_pkg::ALU_ADD;              // no M extension, falls back to add
    end

endmodule

//--- src/branch_resolver.sv
module branch_resolver (
    input  rv_ctrl_pkg::branch_kind_e  i_branch_kind,
    input  rv_ctrl_pkg::pc_sel_e       i_jal_kind,
    input  logic                       i_compare_lt,
    input  logic                       i_compare_eq,
    output rv_ctrl_pkg::pc_sel_e       o_pcsrc,
    output logic                       o_flush
);

    logic taken;

    always_comb
    begin
        // lt already reflects signed or unsigned compare
        case (i_branch_kind)
            rv_ctrl_pkg::BR_EQ: taken = i_compare_eq;
            rv_ctrl_pkg::BR_NE: taken = ~i_compare_eq;
            rv_ctrl_pkg::BR_LT: taken = i_compare_lt;
            rv_ctrl_pkg::BR_GE: taken = ~i_compare_lt;
            default:            taken = 1'b0;
        endcase
    end

    always_comb
    begin
        if (i_jal_kind != rv_ctrl_pkg::PC_PC4)
            o_pcsrc = i_jal_kind;                       // jumps are unconditional
        else if (taken)
            o_pcsrc = rv_ctrl_pkg::PC_BRANCH;
        else
            o_pcsrc = rv_ctrl_pkg::PC_PC4;
    end

    assign o_flush = (o_pcsrc != rv_ctrl_pkg::PC_PC4);  // squash the fetched instr

endmodule

//--- src/control_unit.sv
module control_unit #(
    parameter int REG_ADDR_W = rv_ctrl_pkg::REG_ADDR_DEFAULT
) (
    input  logic [6:0]             i_opcode,
    input  logic [2:0]             i_funct3,
    input  logic [6:0]             i_funct7,
    input  logic [REG_ADDR_W-1:0]  i_rs1,
    input  logic [REG_ADDR_W-1:0]  i_rs2,
    input  logic                   i_compare_lt,
    input  logic                   i_compare_eq,
    input  logic                   i_exe_wreg,
    input  logic                   i_exe_mem2reg,
    input  logic [REG_ADDR_W-1:0]  i_exe_rd,
    input  logic                   i_mem_wreg,
    input  logic                   i_mem_mem2reg,
    input  logic [REG_ADDR_W-1:0]  i_mem_rd,
    output rv_ctrl_pkg::alu_op_e   o_aluc,
    output rv_ctrl_pkg::pc_sel_e   o_pcsrc,
    output rv_ctrl_pkg::fwd_sel_e  o_fwda,
    output rv_ctrl_pkg::fwd_sel_e  o_fwdb,
    output logic                   o_not_stall,
    output logic                   o_flush,
    output logic                   o_wreg,
    output logic                   o_wmem,
    output logic                   o_mem2reg,
    output logic                   o_aluimm,
    output logic                   o_jal,
    output logic                   o_jalr,
    output logic                   o_signext,
    output logic                   o_auipc,
    output logic                   o_ls_b,
    output logic                   o_ls_h,
    output logic                   o_load_signext,
    output logic                   o_slt_instr,
    output logic                   o_compare_signed,
    output logic                   o_compare_imm
);

    logic                       is_arith;
    logic                       is_imm;
    rv_ctrl_pkg::alu_op_e       fixed_op;
    rv_ctrl_pkg::branch_kind_e  branch_kind;
    rv_ctrl_pkg::pc_sel_e       jal_kind;
    logic                       wreg_raw;
    logic                       wmem_raw;
    logic                       use_rs1;
    logic                       use_rs2;

    instr_decoder instr_decoder_i (
        .i_opcode         (i_opcode),
        .i_funct3         (i_funct3),
        .i_funct7         (i_funct7),
        .o_is_arith       (is_arith),
        .o_is_imm         (is_imm),
        .o_fixed_op       (fixed_op),
        .o_branch_kind    (branch_kind),
        .o_jal_kind       (jal_kind),
        .o_wreg_raw       (wreg_raw),
        .o_wmem_raw       (wmem_raw),
        .o_use_rs1        (use_rs1),
        .o_use_rs2        (use_rs2),
        .o_mem2reg        (o_mem2reg),
        .o_aluimm         (o_aluimm),
        .o_jal            (o_jal),
        .o_jalr           (o_jalr),
        .o_signext        (o_signext),
        .o_auipc          (o_auipc),
        .o_ls_b           (o_ls_b),
        .o_ls_h           (o_ls_h),
        .o_load_signext   (o_load_signext),
        .o_slt_instr      (o_slt_instr),
        .o_compare_signed (o_compare_signed),
        .o_compare_imm    (o_compare_imm)
    );

    alu_op_decoder alu_op_decoder_i (
        .i_is_arith (is_arith),
        .i_is_imm   (is_imm),
        .i_funct3   (i_funct3),
        .i_funct7   (i_funct7),
        .i_fixed_op (fixed_op),
        .o_aluc     (o_aluc)
    );

    branch_resolver branch_resolver_i (
        .i_branch_kind (branch_kind),
        .i_jal_kind    (jal_kind),
        .i_compare_lt  (i_compare_lt),
        .i_compare_eq  (i_compare_eq),
        .o_pcsrc       (o_pcsrc),
        .o_flush       (o_flush)
    );

    hazard_unit #(
        .REG_ADDR_W (REG_ADDR_W)
    ) hazard_unit_i (
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_use_rs1     (use_rs1),
        .i_use_rs2     (use_rs2),
        .i_exe_wreg    (i_exe_wreg),
        .i_exe_mem2reg (i_exe_mem2reg),
        .i_exe_rd      (i_exe_rd),
        .i_wreg_raw    (wreg_raw),
        .i_wmem_raw    (wmem_raw),
        .o_not_stall   (o_not_stall),
        .o_wreg        (o_wreg),
        .o_wmem        (o_wmem)
    );

    // operand a
    forward_unit #(
        .REG_ADDR_W (REG_ADDR_W)
    ) forward_a_i (
        .i_rs          (i_rs1),
        .i_exe_wreg    (i_exe_wreg),
        .i_exe_mem2reg (i_exe_mem2reg),
        .i_exe_rd      (i_exe_rd),
        .i_mem_wreg    (i_mem_wreg),
        .i_mem_mem2reg (i_mem_mem2reg),
        .i_mem_rd      (i_mem_rd),
        .o_fwd         (o_fwda)
    );

    // operand b
    forward_unit #(
        .REG_ADDR_W (REG_ADDR_W)
    ) forward_b_i (
        .i_rs          (i_rs2),
        .i_exe_wreg    (i_exe_wreg),
        .i_exe_mem2reg (i_exe_mem2reg),
        .i_exe_rd      (i_exe_rd),
        .i_mem_wreg    (i_mem_wreg),
        .i_mem_mem2reg (i_mem_mem2reg),
        .i_mem_rd      (i_mem_rd),
        .o_fwd         (o_fwdb)
    );

endmodule

//--- src/forward_unit.sv
module forward_unit #(
    parameter int REG_ADDR_W = 5
) (
    input  logic [REG_ADDR_W-1:0]  i_rs,
    input  logic                   i_exe_wreg,
    input  logic                   i_exe_mem2reg,
    input  logic [REG_ADDR_W-1:0]  i_exe_rd,
    input  logic                   i_mem_wreg,
    input  logic                   i_mem_mem2reg,
    input  logic [REG_ADDR_W-1:0]  i_mem_rd,
    output rv_ctrl_pkg::fwd_sel_e  o_fwd
);

    logic exe_hit;
    logic mem_hit;

    // x0 is hardwired, never a producer
    assign exe_hit = i_exe_wreg && (i_exe_rd != '0) && (i_exe_rd == i_rs);
    assign mem_hit = i_mem_wreg && (i_mem_rd != '0) && (i_mem_rd == i_rs);

    always_comb
    begin
        if (exe_hit && !i_exe_mem2reg)
            o_fwd = rv_ctrl_pkg::FWD_EXE_ALU;           // youngest result wins
        else if (mem_hit && !i_mem_mem2reg)
            o_fwd = rv_ctrl_pkg::FWD_MEM_ALU;
        else if (mem_hit)
            o_fwd = rv_ctrl_pkg::FWD_MEM_LOAD;          // load data from dmem
        else
            o_fwd = rv_ctrl_pkg::FWD_NONE;
    end

endmodule

//--- src/hazard_unit.sv
module hazard_unit #(
    parameter int REG_ADDR_W = 5
) (
    input  logic [REG_ADDR_W-1:0]  i_rs1,
    input  logic [REG_ADDR_W-1:0]  i_rs2,
    input  logic                   i_use_rs1,
    input  logic                   i_use_rs2,
    input  logic                   i_exe_wreg,
    input  logic                   i_exe_mem2reg,
    input  logic [REG_ADDR_W-1:0]  i_exe_rd,
    input  logic                   i_wreg_raw,
    input  logic                   i_wmem_raw,
    output logic                   o_not_stall,
    output logic                   o_wreg,
    output logic                   o_wmem
);

    logic load_in_exe;
    logic stall;

    assign load_in_exe = i_exe_wreg && i_exe_mem2reg && (i_exe_rd != '0);

    // only operands the instr really reads can hazard
    assign stall = load_in_exe &&
                   ((i_use_rs1 && (i_exe_rd == i_rs1)) || (i_use_rs2 && (i_exe_rd == i_rs2)));

    assign o_not_stall = ~stall;
    assign o_wreg      = i_wreg_raw & o_not_stall;     // bubble must not commit
    assign o_wmem      = i_wmem_raw & o_not_stall;

endmodule

//--- src/instr_decoder.sv
module instr_decoder (
    input  logic [6:0]                 i_opcode,
    input  logic [2:0]                 i_funct3,
    input  logic [6:0]                 i_funct7,
    output logic                       o_is_arith,
    output logic                       o_is_imm,
    output rv_ctrl_pkg::alu_op_e       o_fixed_op,
    output rv_ctrl_pkg::branch_kind_e  o_branch_kind,
    output rv_ctrl_pkg::pc_sel_e       o_jal_kind,
    output logic                       o_wreg_raw,
    output logic                       o_wmem_raw,
    output logic                       o_use_rs1,
    output logic                       o_use_rs2,
    output logic                       o_mem2reg,
    output logic                       o_aluimm,
    output logic                       o_jal,
    output logic                       o_jalr,
    output logic                       o_signext,
    output logic                       o_auipc,
    output logic                       o_ls_b,
    output logic                       o_ls_h,
    output logic                       o_load_signext,
    output logic                       o_slt_instr,
    output logic                       o_compare_signed,
    output logic                       o_compare_imm
);

    always_comb
    begin
        // illegal opcodes keep every bit at zero
        o_is_arith       = 1'b0;
        o_is_imm         = 1'b0;
        o_fixed_op       = rv_ctrl_pkg::ALU_AND;
        o_branch_kind    = rv_ctrl_pkg::BR_NONE;
        o_jal_kind       = rv_ctrl_pkg::PC_PC4;
        o_wreg_raw       = 1'b0;
        o_wmem_raw       = 1'b0;
        o_use_rs1        = 1'b0;
        o_use_rs2        = 1'b0;
        o_mem2reg        = 1'b0;
        o_aluimm         = 1'b0;
        o_jal            = 1'b0;
        o_jalr           = 1'b0;
        o_signext        = 1'b0;
        o_auipc          = 1'b0;
        o_ls_b           = 1'b0;
        o_ls_h           = 1'b0;
        o_load_signext   = 1'b0;
        o_slt_instr      = 1'b0;
        o_compare_signed = 1'b0;
        o_compare_imm    = 1'b0;

        case (i_opcode)
            rv_ctrl_pkg::OP_R_TYPE:
            begin
                o_is_arith = 1'b1;
                o_wreg_raw = 1'b1;
                o_signext  = 1'b1;
                o_use_rs1  = 1'b1;
                o_use_rs2  = 1'b1;
                if (i_funct7 == rv_ctrl_pkg::FUNCT7_BASE && i_funct3[2:1] == 2'b01)
                begin
                    o_slt_instr      = 1'b1;              // slt / sltu
                    o_compare_signed = ~i_funct3[0];
                end
            end
            rv_ctrl_pkg::OP_I_ALU:
            begin
                o_is_arith = 1'b1;
                o_is_imm   = 1'b1;
                o_wreg_raw = 1'b1;
                o_aluimm   = 1'b1;
                o_signext  = (i_funct3[1:0] != 2'b01);   // shamt is unsigned
                o_use_rs1  = 1'b1;
                if (i_funct3[2:1] == 2'b01)
                begin
                    o_slt_instr      = 1'b1;              // slti / sltiu
                    o_compare_signed = ~i_funct3[0];
                    o_compare_imm    = 1'b1;
                end
            end
            rv_ctrl_pkg::OP_BRANCH:
            begin
                o_signext        = 1'b1;
                o_use_rs1        = 1'b1;
                o_use_rs2        = 1'b1;
                o_compare_signed = ~i_funct3[1];          // bltu / bgeu compare unsigned
                case (i_funct3)
                    3'b000:  o_branch_kind = rv_ctrl_pkg::BR_EQ;
                    3'b001:  o_branch_kind = rv_ctrl_pkg::BR_NE;
                    3'b100,
                    3'b110:  o_branch_kind = rv_ctrl_pkg::BR_LT;
                    3'b101,
                    3'b111:  o_branch_kind = rv_ctrl_pkg::BR_GE;
                    default:
                    begin
                        o_branch_kind    = rv_ctrl_pkg::BR_NONE;
                        o_compare_signed = 1'b0;
                    end
                endcase
            end
            rv_ctrl_pkg::OP_LOAD:
            begin
                o_wreg_raw     = 1'b1;
                o_mem2reg      = 1'b1;
                o_aluimm       = 1'b1;
                o_signext      = 1'b1;
                o_use_rs1      = 1'b1;
                o_fixed_op     = rv_ctrl_pkg::ALU_ADD;    // base + offset
                o_ls_b         = (i_funct3 == 3'b000) || (i_funct3 == 3'b100);
                o_ls_h         = (i_funct3 == 3'b001) || (i_funct3 == 3'b101);
                o_load_signext = (i_funct3 == 3'b000) || (i_funct3 == 3'b001);
            end
            rv_ctrl_pkg::OP_STORE:
            begin
                o_wmem_raw = 1'b1;
                o_aluimm   = 1'b1;
                o_signext  = 1'b1;
                o_use_rs1  = 1'b1;
                o_use_rs2  = 1'b1;                        // store data
                o_fixed_op = rv_ctrl_pkg::ALU_ADD;
                o_ls_b     = (i_funct3 == 3'b000);
                o_ls_h     = (i_funct3 == 3'b001);
            end
            rv_ctrl_pkg::OP_LUI:
            begin
                o_wreg_raw = 1'b1;
                o_aluimm   = 1'b1;
                o_fixed_op = rv_ctrl_pkg::ALU_LUI;
            end
            rv_ctrl_pkg::OP_AUIPC:
            begin
                o_wreg_raw = 1'b1;
                o_aluimm   = 1'b1;
                o_signext  = 1'b1;
                o_auipc    = 1'b1;                        // pc as operand a
                o_fixed_op = rv_ctrl_pkg::ALU_ADD;
            end
            rv_ctrl_pkg::OP_JAL:
            begin
                o_wreg_raw = 1'b1;
                o_jal      = 1'b1;
                o_jal_kind = rv_ctrl_pkg::PC_JAL;
            end
            rv_ctrl_pkg::OP_JALR:
            begin
                o_wreg_raw = 1'b1;
                o_jal      = 1'b1;                        // link write as for jal
                o_jalr     = 1'b1;
                o_signext  = 1'b1;
                o_use_rs1  = 1'b1;
                o_jal_kind = rv_ctrl_pkg::PC_JALR;
            end
            default:
            begin
                o_wreg_raw = 1'b0;
            end
        endcase
    end

endmodule

//--- src/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    localparam int REG_ADDR_DEFAULT = 5;     // x0..x31

    // major opcodes kept in this core
    typedef enum logic [6:0] {
        OP_R_TYPE = 7'b0110011,
        OP_I_ALU  = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;    // sub and sra

    // codes understood by the datapath ALU
    typedef enum logic [4:0] {
        ALU_AND = 5'd0,
        ALU_OR  = 5'd1,
        ALU_ADD = 5'd2,
        ALU_SUB = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRL = 5'd5,
        ALU_SRA = 5'd6,
        ALU_XOR = 5'd7,
        ALU_LUI = 5'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE     = 2'd0,     // register file value
        FWD_EXE_ALU  = 2'd1,
        FWD_MEM_ALU  = 2'd2,
        FWD_MEM_LOAD = 2'd3
    } fwd_sel_e;

    typedef enum logic [1:0] {
        PC_PC4    = 2'd0,
        PC_JALR   = 2'd1,
        PC_JAL    = 2'd2,
        PC_BRANCH = 2'd3
    } pc_sel_e;

    // unsigned branches reuse LT and GE
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } branch_kind_e;

endpackage

//--- tb/control_input.txt
# name opcode(hex) funct3 funct7(hex) rs1 rs2 lt eq exe_wreg exe_mem2reg exe_rd mem_wreg mem_mem2reg mem_rd
#   then expected: aluc pcsrc fwda fwdb not_stall flush wreg wmem
r_add              33 0 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
r_sub              33 0 20  1 2  0 0  0 0 0  0 0 0   3 0 0 0 1 0 1 0
r_sll              33 1 00  1 2  0 0  0 0 0  0 0 0   4 0 0 0 1 0 1 0
r_slt              33 2 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
r_sltu             33 3 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
r_xor              33 4 00  1 2  0 0  0 0 0  0 0 0   7 0 0 0 1 0 1 0
r_srl              33 5 00  1 2  0 0  0 0 0  0 0 0   5 0 0 0 1 0 1 0
r_sra              33 5 20  1 2  0 0  0 0 0  0 0 0   6 0 0 0 1 0 1 0
r_or               33 6 00  1 2  0 0  0 0 0  0 0 0   1 0 0 0 1 0 1 0
r_and              33 7 00  1 2  0 0  0 0 0  0 0 0   0 0 0 0 1 0 1 0
i_addi             13 0 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
i_addi_alt         13 0 20  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
i_slli             13 1 00  1 2  0 0  0 0 0  0 0 0   4 0 0 0 1 0 1 0
i_slti             13 2 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
i_sltiu            13 3 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
i_xori             13 4 00  1 2  0 0  0 0 0  0 0 0   7 0 0 0 1 0 1 0
i_srli             13 5 00  1 2  0 0  0 0 0  0 0 0   5 0 0 0 1 0 1 0
i_srai             13 5 20  1 2  0 0  0 0 0  0 0 0   6 0 0 0 1 0 1 0
i_ori              13 6 00  1 2  0 0  0 0 0  0 0 0   1 0 0 0 1 0 1 0
i_andi             13 7 00  1 2  0 0  0 0 0  0 0 0   0 0 0 0 1 0 1 0
ld_lw              03 2 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
st_sw              23 2 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 0 1
lui                37 0 00  1 2  0 0  0 0 0  0 0 0   8 0 0 0 1 0 1 0
auipc              17 0 00  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
m_mul              33 0 01  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
m_rem              33 6 01  1 2  0 0  0 0 0  0 0 0   2 0 0 0 1 0 1 0
illegal_7f         7f 0 00  1 2  0 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
illegal_00         00 0 00  1 2  0 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
beq_00             63 0 00  1 2  0 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
beq_01             63 0 00  1 2  0 1  0 0 0  0 0 0   0 3 0 0 1 1 0 0
beq_10             63 0 00  1 2  1 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
beq_11             63 0 00  1 2  1 1  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bne_00             63 1 00  1 2  0 0  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bne_01             63 1 00  1 2  0 1  0 0 0  0 0 0   0 0 0 0 1 0 0 0
bne_10             63 1 00  1 2  1 0  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bne_11             63 1 00  1 2  1 1  0 0 0  0 0 0   0 0 0 0 1 0 0 0
blt_00             63 4 00  1 2  0 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
blt_01             63 4 00  1 2  0 1  0 0 0  0 0 0   0 0 0 0 1 0 0 0
blt_10             63 4 00  1 2  1 0  0 0 0  0 0 0   0 3 0 0 1 1 0 0
blt_11             63 4 00  1 2  1 1  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bge_00             63 5 00  1 2  0 0  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bge_01             63 5 00  1 2  0 1  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bge_10             63 5 00  1 2  1 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
bge_11             63 5 00  1 2  1 1  0 0 0  0 0 0   0 0 0 0 1 0 0 0
bltu_10            63 6 00  1 2  1 0  0 0 0  0 0 0   0 3 0 0 1 1 0 0
bgeu_10            63 7 00  1 2  1 0  0 0 0  0 0 0   0 0 0 0 1 0 0 0
branch_bad_f3      63 2 00  1 2  1 1  0 0 0  0 0 0   0 0 0 0 1 0 0 0
jal                6f 0 00  1 2  1 1  0 0 0  0 0 0   0 2 0 0 1 1 1 0
jalr               67 0 00  1 2  0 0  0 0 0  0 0 0   0 1 0 0 1 1 1 0
fwd_exe_a          33 0 00  5 6  0 0  1 0 5  0 0 0   2 0 1 0 1 0 1 0
fwd_exe_over_mem_b 33 0 00  5 6  0 0  1 0 6  1 0 6   2 0 0 1 1 0 1 0
fwd_exe_over_ld_a  33 0 00  5 6  0 0  1 0 5  1 1 5   2 0 1 0 1 0 1 0
fwd_mem_alu_a      33 0 00  5 6  0 0  0 0 0  1 0 5   2 0 2 0 1 0 1 0
fwd_mem_load_b     33 0 00  5 6  0 0  0 0 0  1 1 6   2 0 0 3 1 0 1 0
fwd_mem_both       33 0 00  5 5  0 0  0 0 0  1 0 5   2 0 2 2 1 0 1 0
fwd_rd_zero        33 0 00  0 0  0 0  1 0 0  1 0 0   2 0 0 0 1 0 1 0
fwd_wreg_low       33 0 00  5 5  0 0  0 0 5  0 0 5   2 0 0 0 1 0 1 0
stall_add_rs2      33 0 00  1 7  0 0  1 1 7  0 0 0   2 0 0 0 0 0 0 0
stall_add_mem_a    33 0 00  5 6  0 0  1 1 5  1 0 5   2 0 2 0 0 0 0 0
stall_sw_data      23 2 00  1 7  0 0  1 1 7  0 0 0   2 0 0 0 0 0 0 0
stall_sw_base      23 2 00  7 2  0 0  1 1 7  0 0 0   2 0 0 0 0 0 0 0
stall_beq          63 0 00  7 2  0 1  1 1 7  0 0 0   0 3 0 0 0 1 0 0
stall_jalr         67 0 00  7 2  0 0  1 1 7  0 0 0   0 1 0 0 0 1 0 0
nostall_lui        37 0 00  7 7  0 0  1 1 7  0 0 0   8 0 0 0 1 0 1 0
nostall_addi_rs2   13 0 00  1 7  0 0  1 1 7  0 0 0   2 0 0 0 1 0 1 0
nostall_rd_zero    33 0 00  0 0  0 0  1 1 0  0 0 0   2 0 0 0 1 0 1 0
nostall_exe_nowreg 33 0 00  1 7  0 0  0 1 7  0 0 0   2 0 0 0 1 0 1 0
nostall_jal        6f 0 00  7 7  0 0  1 1 7  0 0 0   0 2 0 0 1 1 1 0
nostall_illegal    7f 0 00  7 7  0 0  1 1 7  0 0 0   0 0 0 0 1 0 0 0

//--- tb/tb_control_unit.sv
module tb_control_unit;

    localparam int REG_W     = rv_ctrl_pkg::REG_ADDR_DEFAULT;
    localparam int MAX_LINES = 200;             // read loop bound

    logic clk;

    // DUT inputs
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_W-1:0]  rs1;
    logic [REG_W-1:0]  rs2;
    logic              compare_lt;
    logic              compare_eq;
    logic              exe_wreg;
    logic              exe_mem2reg;
    logic [REG_W-1:0]  exe_rd;
    logic              mem_wreg;
    logic              mem_mem2reg;
    logic [REG_W-1:0]  mem_rd;

    // DUT outputs
    rv_ctrl_pkg::alu_op_e   aluc;
    rv_ctrl_pkg::pc_sel_e   pcsrc;
    rv_ctrl_pkg::fwd_sel_e  fwda;
    rv_ctrl_pkg::fwd_sel_e  fwdb;
    logic not_stall;
    logic flush;
    logic wreg;
    logic wmem;
    logic mem2reg;
    logic aluimm;
    logic jal;
    logic jalr;
    logic signext;
    logic auipc;
    logic ls_b;
    logic ls_h;
    logic load_signext;
    logic slt_instr;
    logic compare_signed;
    logic compare_imm;

    // one parsed vector
    logic [8*32-1:0]   v_name;
    logic [6:0]        v_opcode;
    logic [2:0]        v_funct3;
    logic [6:0]        v_funct7;
    logic [REG_W-1:0]  v_rs1;
    logic [REG_W-1:0]  v_rs2;
    logic              v_lt;
    logic              v_eq;
    logic              v_exe_wreg;
    logic              v_exe_mem2reg;
    logic [REG_W-1:0]  v_exe_rd;
    logic              v_mem_wreg;
    logic              v_mem_mem2reg;
    logic [REG_W-1:0]  v_mem_rd;
    logic [4:0]        exp_aluc;
    logic [1:0]        exp_pcsrc;
    logic [1:0]        exp_fwda;
    logic [1:0]        exp_fwdb;
    logic              exp_not_stall;
    logic              exp_flush;
    logic              exp_wreg;
    logic              exp_wmem;

    int    fd;
    int    line_count;
    int    vec_count;
    int    n_fields;
    bit    done;
    string line;

    control_unit #(
        .REG_ADDR_W (REG_W)
    ) control_unit_i (
        .i_opcode         (opcode),
        .i_funct3         (funct3),
        .i_funct7         (funct7),
        .i_rs1            (rs1),
        .i_rs2            (rs2),
        .i_compare_lt     (compare_lt),
        .i_compare_eq     (compare_eq),
        .i_exe_wreg       (exe_wreg),
        .i_exe_mem2reg    (exe_mem2reg),
        .i_exe_rd         (exe_rd),
        .i_mem_wreg       (mem_wreg),
        .i_mem_mem2reg    (mem_mem2reg),
        .i_mem_rd         (mem_rd),
        .o_aluc           (aluc),
        .o_pcsrc          (pcsrc),
        .o_fwda           (fwda),
        .o_fwdb           (fwdb),
        .o_not_stall      (not_stall),
        .o_flush          (flush),
        .o_wreg           (wreg),
        .o_wmem           (wmem),
        .o_mem2reg        (mem2reg),
        .o_aluimm         (aluimm),
        .o_jal            (jal),
        .o_jalr           (jalr),
        .o_signext        (signext),
        .o_auipc          (auipc),
        .o_ls_b           (ls_b),
        .o_ls_h           (ls_h),
        .o_load_signext   (load_signext),
        .o_slt_instr      (slt_instr),
        .o_compare_signed (compare_signed),
        .o_compare_imm    (compare_imm)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // paces the vectors only
    end

    task automatic report_error(input string reason);
        $display("ERROR: %s", reason);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [8*32-1:0] name, input string field,
                               input logic [7:0] expected, input logic [7:0] actual);
        assert (actual == expected)
        else
        begin
            $display("MISMATCH %0s %s expected %0d actual %0d", name, field, expected, actual);
            $display("Some tests failed");
            $fatal(1, "output check failed");
        end
    endtask

    // side-band bits per RV32I class, msb first
    // mem2reg aluimm jal jalr signext auipc ls_b ls_h load_signext slt cmp_signed cmp_imm
    function automatic logic [11:0] expected_sideband(input logic [6:0] op,
                                                      input logic [2:0] f3,
                                                      input logic [6:0] f7);
        logic        is_slt;
        logic [11:0] bits;
        is_slt = (f3 == 3'd2) || (f3 == 3'd3);
        case (op)
            7'h33:
            begin
                bits    = 12'b0000_1000_0000;
                bits[2] = (f7 == 7'h00) && is_slt;
                bits[1] = (f7 == 7'h00) && (f3 == 3'd2);
            end
            7'h13:
            begin
                bits    = 12'b0100_1000_0000;
                bits[7] = (f3 != 3'd1) && (f3 != 3'd5);     // shift amounts unsigned
                bits[2] = is_slt;
                bits[1] = (f3 == 3'd2);
                bits[0] = is_slt;
            end
            7'h63:
            begin
                bits    = 12'b0000_1000_0000;
                bits[1] = (f3 == 3'd0) || (f3 == 3'd1) ||   // signed compares only
                          (f3 == 3'd4) || (f3 == 3'd5);
            end
            7'h03:
            begin
                bits    = 12'b1100_1000_0000;
                bits[5] = (f3 == 3'd0) || (f3 == 3'd4);     // lb, lbu
                bits[4] = (f3 == 3'd1) || (f3 == 3'd5);     // lh, lhu
                bits[3] = (f3 == 3'd0) || (f3 == 3'd1);
            end
            7'h23:
            begin
                bits    = 12'b0100_1000_0000;
                bits[5] = (f3 == 3'd0);
                bits[4] = (f3 == 3'd1);
            end
            7'h37:   bits = 12'b0100_0000_0000;             // lui
            7'h17:   bits = 12'b0100_1100_0000;             // auipc
            7'h6f:   bits = 12'b0010_0000_0000;             // jal
            7'h67:   bits = 12'b0011_1000_0000;             // jalr
            default: bits = '0;                             // illegal, all off
        endcase
        return bits;
    endfunction

    task automatic drive_vector();
        opcode      = v_opcode;
        funct3      = v_funct3;
        funct7      = v_funct7;
        rs1         = v_rs1;
        rs2         = v_rs2;
        compare_lt  = v_lt;
        compare_eq  = v_eq;
        exe_wreg    = v_exe_wreg;
        exe_mem2reg = v_exe_mem2reg;
        exe_rd      = v_exe_rd;
        mem_wreg    = v_mem_wreg;
        mem_mem2reg = v_mem_mem2reg;
        mem_rd      = v_mem_rd;
    endtask

    task automatic check_outputs();
        logic [11:0] exp_side;
        exp_side = expected_sideband(v_opcode, v_funct3, v_funct7);
        check_value(v_name, "aluc", {3'b000, exp_aluc}, {3'b000, aluc});
        check_value(v_name, "pcsrc", {6'b0, exp_pcsrc}, {6'b0, pcsrc});
        check_value(v_name, "fwda", {6'b0, exp_fwda}, {6'b0, fwda});
        check_value(v_name, "fwdb", {6'b0, exp_fwdb}, {6'b0, fwdb});
        check_value(v_name, "not_stall", {7'b0, exp_not_stall}, {7'b0, not_stall});
        check_value(v_name, "flush", {7'b0, exp_flush}, {7'b0, flush});
        check_value(v_name, "wreg", {7'b0, exp_wreg}, {7'b0, wreg});
        check_value(v_name, "wmem", {7'b0, exp_wmem}, {7'b0, wmem});
        check_value(v_name, "mem2reg", {7'b0, exp_side[11]}, {7'b0, mem2reg});
        check_value(v_name, "aluimm", {7'b0, exp_side[10]}, {7'b0, aluimm});
        check_value(v_name, "jal", {7'b0, exp_side[9]}, {7'b0, jal});
        check_value(v_name, "jalr", {7'b0, exp_side[8]}, {7'b0, jalr});
        check_value(v_name, "signext", {7'b0, exp_side[7]}, {7'b0, signext});
        check_value(v_name, "auipc", {7'b0, exp_side[6]}, {7'b0, auipc});
        check_value(v_name, "ls_b", {7'b0, exp_side[5]}, {7'b0, ls_b});
        check_value(v_name, "ls_h", {7'b0, exp_side[4]}, {7'b0, ls_h});
        check_value(v_name, "load_signext", {7'b0, exp_side[3]}, {7'b0, load_signext});
        check_value(v_name, "slt_instr", {7'b0, exp_side[2]}, {7'b0, slt_instr});
        check_value(v_name, "compare_signed", {7'b0, exp_side[1]}, {7'b0, compare_signed});
        check_value(v_name, "compare_imm", {7'b0, exp_side[0]}, {7'b0, compare_imm});
    endtask

    initial
    begin
        opcode      = '0;
        funct3      = '0;
        funct7      = '0;
        rs1         = '0;
        rs2         = '0;
        compare_lt  = 1'b0;
        compare_eq  = 1'b0;
        exe_wreg    = 1'b0;
        exe_mem2reg = 1'b0;
        exe_rd      = '0;
        mem_wreg    = 1'b0;
        mem_mem2reg = 1'b0;
        mem_rd      = '0;
        done        = 1'b0;
        line_count  = 0;
        vec_count   = 0;

        fd = $fopen("tb/control_input.txt", "r");
        if (fd == 0)
            report_error("cannot open the vector file tb/control_input.txt");
        else
        begin
            repeat (2) @(posedge clk);          // idle cycles, no reset port
            while (!done && line_count < MAX_LINES)
            begin
                if ($fgets(line, fd) == 0)
                    done = 1'b1;
                else
                begin
                    line_count++;
                    if (line.len() > 1 && line.getc(0) != "#")
                    begin
                        v_name = '0;
                        n_fields = $sscanf(line,
                            "%s %h %d %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            v_name, v_opcode, v_funct3, v_funct7, v_rs1, v_rs2, v_lt, v_eq,
                            v_exe_wreg, v_exe_mem2reg, v_exe_rd,
                            v_mem_wreg, v_mem_mem2reg, v_mem_rd,
                            exp_aluc, exp_pcsrc, exp_fwda, exp_fwdb,
                            exp_not_stall, exp_flush, exp_wreg, exp_wmem);
                        if (n_fields != 22)
                            report_error($sformatf("malformed vector on line %0d", line_count));
                        else
                        begin
                            #1;                 // drive just after the edge
                            drive_vector();
                            @(posedge clk);
                            check_outputs();
                            vec_count++;
                        end
                    end
                end
            end
            $fclose(fd);

            if (!done)
                report_error($sformatf("read limit of %0d lines hit before end of file",
                                       MAX_LINES));
            else if (vec_count == 0)
                report_error("no test vectors found in tb/control_input.txt");
            else
            begin
                $display("All tests passed");
                $finish;
            end
        end
    end

endmodule
